/* loopTrack.f */
hw/loopPkg.sv
hw/loopRegsAxi.sv
hw/loopErrorScale.sv
hw/loopIntegrator.sv
hw/loopLockDetect.sv
hw/loopFilterTop.sv
verif/loopFilterAssert.sv
verif/loopFilterTb.sv

/* verif/loopFilterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module loopFilterTb;
    import loopPkg::*;

    localparam int period     = 8;
    localparam int maxSamples = 500;
    localparam int maxAxiOps  = 160;
    localparam int wdCycles   = maxSamples * 8 + maxAxiOps * 40 + 2000;

    logic                   clk;
    logic                   reset;
    axiLiteReq_t            axiReq;
    axiLiteRsp_t            axiRsp;
    logic signed [errW-1:0] error;
    logic                   errorValid;
    logic [dataW-1:0]       loopFreq;
    logic                   freqValid;
    logic                   satPos;
    logic                   satNeg;
    logic                   locked;

    logic [31:0]      lfsr = 32'h5e48;
    int               errors = 0;
    int               checks = 0;
    logic [2:0]       vPipe;      // errorValid delayed, one bit per edge
    logic [1:0]       satExp;
    logic [31:0]      shadow [4];
    loopCfg_t         mCfg;       // model copy of the registers
    loopStatus_t      mStat;
    int               mRun;
    logic [31:0]      freqQ [$];
    logic             lockQ [$];
    logic [1:0]       satQ [$];

    loopFilterTop UUT (
        .clk        (clk),
        .reset      (reset),
        .axiReq     (axiReq),
        .axiRsp     (axiRsp),
        .error      (error),
        .errorValid (errorValid),
        .loopFreq   (loopFreq),
        .freqValid  (freqValid),
        .satPos     (satPos),
        .satNeg     (satNeg),
        .locked     (locked)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] withSign(input int mag);
        return (randBits(1) != 0) ? 12'(-mag) : 12'(mag);
    endfunction

    // 2^(k-11) gain, right shifts round toward minus infinity
    function automatic logic [31:0] gainTerm(input logic signed [11:0] e, input logic [4:0] k);
        longint v;
        longint d;
        v = e;
        if (k == 0) return '0;
        if (k >= 11) return 32'(v * (longint'(1) << (k - 11)));
        d = longint'(1) << (11 - k);
        if (v < 0) return 32'((v - d + 1) / d);
        return 32'(v / d);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic modelStep(input logic [11:0] e);
        logic [11:0] c;
        logic [31:0] lead;
        logic [31:0] lag;
        longint      sum;
        longint      lim;
        int          mag;
        if (mCfg.zeroError) c = '0;
        else if (mCfg.invertError) c = -e + mCfg.offset;
        else c = e + mCfg.offset;
        mag = $signed(c);
        if (mag < 0) mag = -mag;
        if (mag > int'(mCfg.syncThreshold)) mRun = 0;
        else if (mRun < 65535) mRun++;
        mStat.locked = (mRun >= int'(mCfg.lockCount));
        lead = gainTerm(c, mCfg.leadExp);
        lag  = gainTerm(c, mCfg.lagExp);
        sum  = longint'(mStat.lagAccum) + longint'($signed(lag));
        lim  = longint'($signed(mCfg.limit));
        mStat.satPos = (sum > lim);
        mStat.satNeg = (sum < -lim);
        if (mStat.satPos) mStat.lagAccum = 32'(lim);
        else if (mStat.satNeg) mStat.lagAccum = 32'(-lim);
        else mStat.lagAccum = 32'(sum);
        freqQ.push_back(mStat.lagAccum + lead);
        lockQ.push_back(mStat.locked);
        satQ.push_back({mStat.satPos, mStat.satNeg});
    endtask

    task automatic sendSample(input logic [11:0] e, input int gap);
        error      = e;
        errorValid = 1'b1;
        modelStep(e);
        @(negedge clk);
        errorValid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic drain();
        while (freqQ.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] expResp);
        logic [1:0] resp;
        axiReq.awaddr  = addr;
        axiReq.wdata   = data;
        axiReq.wstrb   = strb;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid  = 1'b1;
        @(negedge clk);
        while (!axiRsp.awready) @(negedge clk);
        @(negedge clk);  // handshake taken on the edge in between
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        while (!(axiRsp.bvalid && axiReq.bready)) begin
            @(negedge clk);
            axiReq.bready = axiRsp.bvalid && (randBits(1) != 0);  // random stall
        end
        resp = axiRsp.bresp;
        @(negedge clk);
        axiReq.bready = 1'b0;
        checkValue("bresp", 32'(resp), 32'(expResp));
    endtask

    task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
                           input logic [1:0] expResp);
        logic [1:0] resp;
        axiReq.araddr  = addr;
        axiReq.arvalid = 1'b1;
        @(negedge clk);
        while (!axiRsp.arready) @(negedge clk);
        @(negedge clk);
        axiReq.arvalid = 1'b0;
        while (!(axiRsp.rvalid && axiReq.rready)) begin
            @(negedge clk);
            axiReq.rready = axiRsp.rvalid && (randBits(1) != 0);
        end
        resp = axiRsp.rresp;
        data = axiRsp.rdata;
        @(negedge clk);
        axiReq.rready = 1'b0;
        checkValue("rresp", 32'(resp), 32'(expResp));
    endtask

    task automatic setConfig(input logic inv, input logic zero, input logic clear,
                             input logic [4:0] lead, input logic [4:0] lag,
                             input logic [31:0] limit, input logic [11:0] offset,
                             input logic [15:0] lockCount, input logic [11:0] thr);
        axiWrite(CTRL, {11'd0, lag, 3'd0, lead, 5'd0, clear, zero, inv}, 4'hf, respOkay);
        axiWrite(LIMIT, limit, 4'hf, respOkay);
        axiWrite(OFFSET, {offset, 20'd0}, 4'hf, respOkay);
        axiWrite(LOCK, {4'd0, thr, lockCount}, 4'hf, respOkay);
        mCfg = '{invertError: inv, zeroError: zero, clearAccum: clear, leadExp: lead,
                 lagExp: lag, limit: limit, offset: offset, lockCount: lockCount,
                 syncThreshold: thr};
        if (clear) begin
            mStat.lagAccum = '0;
            mStat.satPos   = 1'b0;
            mStat.satNeg   = 1'b0;
        end
    endtask

    task automatic testRegisters();
        int          startErr;
        logic [1:0]  idx;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] rd;
        startErr = errors;
        for (int i = 0; i < 24; i++) begin
            idx  = 2'(randBits(2));
            addr = 12'(idx) << 2;
            data = randBits(32);
            strb = 4'(randBits(4));
            axiWrite(addr, data, strb, respOkay);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
            shadow[0][ctrlClearBit] = 1'b0;  // pulse bit reads as zero
            axiRead(addr, rd, respOkay);
            checkValue("rdata", rd, shadow[idx]);
        end
        axiWrite(ACCUM, randBits(32), 4'hf, respSlvErr);
        axiWrite(STATUS, randBits(32), 4'hf, respSlvErr);
        addr = 12'h018 + (12'(randBits(8)) << 2);
        axiWrite(addr, randBits(32), 4'hf, respSlvErr);
        axiRead(addr, rd, respSlvErr);
        checkValue("rdata", rd, '0);
        for (int j = 0; j < 4; j++) begin
            axiRead(12'(j * 4), rd, respOkay);
            checkValue("rdata", rd, shadow[j]);
        end
        axiRead(ACCUM, rd, respOkay);
        checkValue("ACCUM", rd, mStat.lagAccum);
        $display("test 1 register access: %0d errors", errors - startErr);
    endtask

    task automatic testGainPath();
        int startErr;
        startErr = errors;
        for (int r = 0; r < 5; r++) begin
            setConfig(1'(randBits(1)), 1'b0, 1'b0, 5'(randBits(5)), 5'(randBits(4)),
                      32'h4000_0000, (randBits(1) != 0) ? 12'(randBits(12)) : 12'd0,
                      16'd0, 12'd0);
            for (int i = 0; i < 40; i++) begin
                sendSample(12'(randBits(12)), (randBits(2) == 0) ? int'(randBits(2)) : 0);
            end
            drain();
        end
        $display("test 2 gain path: %0d errors", errors - startErr);
    endtask

    task automatic testSaturation();
        int          startErr;
        logic [31:0] limit;
        logic [31:0] rd;
        startErr = errors;
        limit    = 32'd1000 + randBits(12);
        setConfig(1'b0, 1'b0, 1'b0, 5'd11, 5'd20, limit, 12'd0, 16'd0, 12'd0);
        for (int i = 0; i < 24; i++) sendSample(12'(randBits(10) + 16), int'(randBits(1)));
        drain();
        axiRead(ACCUM, rd, respOkay);
        checkValue("ACCUM", rd, limit);
        axiRead(STATUS, rd, respOkay);
        checkValue("STATUS", rd, {29'd0, 1'b0, 1'b1, mStat.locked});
        for (int i = 0; i < 24; i++) sendSample(12'(-(randBits(10) + 16)), int'(randBits(1)));
        drain();
        axiRead(ACCUM, rd, respOkay);
        checkValue("ACCUM", rd, -limit);
        axiRead(STATUS, rd, respOkay);
        checkValue("STATUS", rd, {29'd0, 1'b1, 1'b0, mStat.locked});
        $display("test 3 saturation: %0d errors", errors - startErr);
    endtask

    task automatic testZeroClear();
        int          startErr;
        logic [31:0] accBefore;
        logic [31:0] rd;
        startErr = errors;
        setConfig(1'b0, 1'b0, 1'b0, 5'd11, 5'd8, 32'h1000_0000, 12'd0, 16'd0, 12'd0);
        for (int i = 0; i < 12; i++) sendSample(12'(randBits(12)), 0);
        drain();
        accBefore = mStat.lagAccum;
        setConfig(1'b0, 1'b1, 1'b0, 5'd11, 5'd8, 32'h1000_0000, 12'd0, 16'd0, 12'd0);
        for (int i = 0; i < 12; i++) sendSample(12'(randBits(12)), int'(randBits(2)));
        drain();
        axiRead(ACCUM, rd, respOkay);
        checkValue("ACCUM", rd, accBefore);  // zeroed error leaves it alone
        setConfig(1'b0, 1'b0, 1'b1, 5'd11, 5'd8, 32'h1000_0000, 12'd0, 16'd0, 12'd0);
        axiRead(ACCUM, rd, respOkay);
        checkValue("ACCUM", rd, '0);
        for (int i = 0; i < 12; i++) sendSample(12'(randBits(12)), 0);
        drain();
        axiRead(ACCUM, rd, respOkay);
        checkValue("ACCUM", rd, mStat.lagAccum);
        $display("test 4 zero and clear: %0d errors", errors - startErr);
    endtask

    task automatic testLock();
        int          startErr;
        int          runLen;
        logic [15:0] lockCount;
        startErr  = errors;
        lockCount = 16'(4 + randBits(3));
        setConfig(1'b0, 1'b0, 1'b0, 5'd11, 5'd0, 32'h7fff_ffff, 12'd0, lockCount, 12'd100);
        for (int r = 0; r < 8; r++) begin
            runLen = 1 + int'(randBits(4));
            for (int i = 0; i < runLen; i++) begin
                sendSample(withSign(int'(randBits(6) + randBits(5))), int'(randBits(1)));
            end
            sendSample(withSign(101 + int'(randBits(10))), 0);  // breaks the run
        end
        drain();
        checkValue("locked", 32'(locked), 32'd0);
        $display("test 5 lock detection: %0d errors", errors - startErr);
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) vPipe <= '0;
        else vPipe <= {vPipe[1:0], errorValid};
    end

    // locked settles two edges after a sample, flags three, loopFreq four
    always @(negedge clk) begin
        if (!reset && vPipe[1]) begin
            assert (lockQ.size() != 0) else begin
                errors++;
                $display("locked updated with no sample outstanding");
            end
            if (lockQ.size() != 0) checkValue("locked", 32'(locked), 32'(lockQ.pop_front()));
        end
        if (!reset && vPipe[2] && satQ.size() != 0) begin
            satExp = satQ.pop_front();
            checkValue("satPos,satNeg", 32'({satPos, satNeg}), 32'(satExp));
        end
        if (!reset && freqValid) begin
            assert (freqQ.size() != 0) else begin
                errors++;
                $display("freqValid pulsed with no sample outstanding");
            end
            if (freqQ.size() != 0) checkValue("loopFreq", loopFreq, freqQ.pop_front());
        end
    end

    initial begin
        #(wdCycles * period);
        $display("watchdog expired after %0d cycles, the tests did not finish", wdCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        axiReq     = '0;
        error      = '0;
        errorValid = 1'b0;
        mCfg       = '0;
        mStat      = '0;
        mRun       = 0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        testRegisters();
        testGainPath();
        testSaturation();
        testZeroClear();
        testLock();
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.bindChecks.failCount);
        if (errors == 0 && UUT.bindChecks.failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/loopFilterAssert.sv */
`timescale 1ns/1ps
`default_nettype none

module loopFilterAssert (
    input  logic                 clk,
    input  logic                 reset,
    input  loopPkg::axiLiteReq_t axiReq,
    input  loopPkg::axiLiteRsp_t axiRsp,
    input  logic                 errorValid,
    input  logic                 freqValid,
    input  logic                 satPos,
    input  logic                 satNeg
);
    int satFails = 0;
    int bFails   = 0;
    int rFails   = 0;
    int latFails = 0;
    int failCount;

    assign failCount = satFails + bFails + rFails + latFails;  // read by the testbench

    satExclusive: assert property (@(posedge clk) disable iff (reset) !(satPos && satNeg))
        else begin
            satFails++;
            $error("satPos and satNeg are high together");
        end

    // response channels hold until the master takes them
    bHold: assert property (@(posedge clk) disable iff (reset)
                            axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
        else begin
            bFails++;
            $error("bvalid dropped before bready");
        end

    rHold: assert property (@(posedge clk) disable iff (reset)
                            axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
        else begin
            rFails++;
            $error("rvalid dropped before rready");
        end

    latForward: assert property (@(posedge clk) disable iff (reset) errorValid |-> ##4 freqValid)
        else begin
            latFails++;
            $error("freqValid missing 4 cycles after errorValid");
        end

    latBack: assert property (@(posedge clk) disable iff (reset)
                              freqValid |-> $past(errorValid, 4))
        else begin
            latFails++;
            $error("freqValid without errorValid 4 cycles earlier");
        end

endmodule

bind loopFilterTop loopFilterAssert bindChecks (
    .clk        (clk),
    .reset      (reset),
    .axiReq     (axiReq),
    .axiRsp     (axiRsp),
    .errorValid (errorValid),
    .freqValid  (freqValid),
    .satPos     (satPos),
    .satNeg     (satNeg)
);

`default_nettype wire

/* hw/loopFilterTop.sv */
`timescale 1ns/1ps
`default_nettype none

module loopFilterTop (
    input  logic                            clk,
    input  logic                            reset,
    input  loopPkg::axiLiteReq_t            axiReq,
    output loopPkg::axiLiteRsp_t            axiRsp,
    input  logic signed [loopPkg::errW-1:0] error,
    input  logic                            errorValid,
    output logic [loopPkg::dataW-1:0]       loopFreq,
    output logic                            freqValid,
    output logic                            satPos,
    output logic                            satNeg,
    output logic                            locked
);
    import loopPkg::*;

    loopCfg_t                cfg;
    loopStatus_t             status;
    scaledTerms_t            terms;
    logic signed [errW-1:0]  condError;
    logic                    valid1;
    logic                    valid2;
    logic signed [dataW-1:0] lagAccum;

    assign status = '{lagAccum: lagAccum, satPos: satPos, satNeg: satNeg, locked: locked};

    loopRegsAxi regs (
        .clk    (clk),
        .reset  (reset),
        .axiReq (axiReq),
        .axiRsp (axiRsp),
        .status (status),
        .cfg    (cfg)
    );

    loopErrorScale scale (
        .clk        (clk),
        .reset      (reset),
        .error      (error),
        .errorValid (errorValid),
        .cfg        (cfg),
        .condError  (condError),
        .valid1     (valid1),
        .terms      (terms),
        .valid2     (valid2)
    );

    loopIntegrator integ (
        .clk        (clk),
        .reset      (reset),
        .terms      (terms),
        .valid2     (valid2),
        .limit      (cfg.limit),
        .clearAccum (cfg.clearAccum),
        .lagAccum   (lagAccum),
        .satPos     (satPos),
        .satNeg     (satNeg),
        .loopFreq   (loopFreq),
        .freqValid  (freqValid)
    );

    loopLockDetect lockDet (
        .clk           (clk),
        .reset         (reset),
        .condError     (condError),
        .valid1        (valid1),
        .lockCount     (cfg.lockCount),
        .syncThreshold (cfg.syncThreshold),
        .locked        (locked)
    );

endmodule

`default_nettype wire

/* hw/loopLockDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module loopLockDetect (
    input  logic                            clk,
    input  logic                            reset,
    input  logic signed [loopPkg::errW-1:0] condError,
    input  logic                            valid1,
    input  logic [loopPkg::cntW-1:0]        lockCount,
    input  logic [loopPkg::errW-1:0]        syncThreshold,
    output logic                            locked
);
    import loopPkg::*;

    logic [errW:0]   magnitude;  // extra bit for -2048
    logic [cntW-1:0] runCount;
    logic [cntW-1:0] nextCount;

    always_comb begin
        magnitude = condError[errW-1] ? -{condError[errW-1], condError}
                                      : {1'b0, condError};
        if (magnitude > {1'b0, syncThreshold}) begin
            nextCount = '0;  // large error breaks the run
        end else if (runCount == '1) begin
            nextCount = runCount;
        end else begin
            nextCount = runCount + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            runCount <= '0;
            locked   <= 1'b0;
        end else if (valid1) begin
            runCount <= nextCount;
            locked   <= nextCount >= lockCount;  // zero count always locks
        end
    end

endmodule

`default_nettype wire

/* hw/loopIntegrator.sv */
`timescale 1ns/1ps
`default_nettype none

module loopIntegrator (
    input  logic                            clk,
    input  logic                            reset,
    input  loopPkg::scaledTerms_t           terms,
    input  logic                            valid2,
    input  logic [loopPkg::dataW-1:0]       limit,
    input  logic                            clearAccum,
    output logic signed [loopPkg::dataW-1:0] lagAccum,
    output logic                            satPos,
    output logic                            satNeg,
    output logic [loopPkg::dataW-1:0]       loopFreq,
    output logic                            freqValid
);
    import loopPkg::*;

    logic signed [dataW:0]   sum;      // one guard bit
    logic signed [dataW:0]   posLim;
    logic signed [dataW:0]   negLim;
    logic signed [dataW-1:0] leadDly;
    logic                    valid3;

    always_comb begin
        sum    = $signed({lagAccum[dataW-1], lagAccum})
               + $signed({terms.lagTerm[dataW-1], terms.lagTerm});
        posLim = $signed({limit[dataW-1], limit});
        negLim = -posLim;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum  <= '0;
            satPos    <= 1'b0;
            satNeg    <= 1'b0;
            valid3    <= 1'b0;
            freqValid <= 1'b0;
        end else begin
            valid3    <= valid2;
            freqValid <= valid3;
            if (clearAccum) begin
                // clear wins over a sample in the same cycle
                lagAccum <= '0;
                satPos   <= 1'b0;
                satNeg   <= 1'b0;
            end else if (valid2) begin
                if (sum > posLim) begin
                    lagAccum <= posLim[dataW-1:0];
                    satPos   <= 1'b1;
                    satNeg   <= 1'b0;
                end else if (sum < negLim) begin
                    lagAccum <= negLim[dataW-1:0];
                    satPos   <= 1'b0;
                    satNeg   <= 1'b1;
                end else begin
                    lagAccum <= sum[dataW-1:0];
                    satPos   <= 1'b0;
                    satNeg   <= 1'b0;
                end
            end
        end
    end

    // lead term lines up with the updated accumulator
    always_ff @(posedge clk) begin
        if (valid2) begin
            leadDly <= terms.leadTerm;
        end
        if (valid3) begin
            loopFreq <= lagAccum + leadDly;  // wraps
        end
    end

endmodule

`default_nettype wire

/* hw/loopErrorScale.sv */
`timescale 1ns/1ps
`default_nettype none

module loopErrorScale (
    input  logic                           clk,
    input  logic                           reset,
    input  logic signed [loopPkg::errW-1:0] error,
    input  logic                           errorValid,
    input  loopPkg::loopCfg_t              cfg,
    output logic signed [loopPkg::errW-1:0] condError,
    output logic                           valid1,
    output loopPkg::scaledTerms_t          terms,
    output logic                           valid2
);
    import loopPkg::*;

    logic signed [errW-1:0] signedErr;
    logic signed [errW-1:0] nextErr;

    // gain of 2^(k - unityExp), zero exponent switches the term off
    function automatic logic signed [dataW-1:0] powerGain(
        input logic signed [errW-1:0] e,
        input logic [expW-1:0]        k
    );
        logic signed [dataW-1:0] ext;
        ext = e;  // sign extended
        if (k == '0) begin
            return '0;
        end else if (k < unityExp) begin
            return ext >>> (unityExp - k);
        end else begin
            return ext << (k - unityExp);
        end
    endfunction

    always_comb begin
        signedErr = cfg.invertError ? -error : error;
        // offset add wraps in 12 bits
        nextErr   = cfg.zeroError ? '0 : signedErr + cfg.offset;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end else begin
            valid1 <= errorValid;
            valid2 <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        if (errorValid) begin
            condError <= nextErr;
        end
        if (valid1) begin
            terms <= '{leadTerm: powerGain(condError, cfg.leadExp),
                       lagTerm:  powerGain(condError, cfg.lagExp)};
        end
    end

endmodule

`default_nettype wire

/* hw/loopRegsAxi.sv */
`timescale 1ns/1ps
`default_nettype none

module loopRegsAxi (
    input  logic                 clk,
    input  logic                 reset,
    input  loopPkg::axiLiteReq_t axiReq,
    output loopPkg::axiLiteRsp_t axiRsp,
    input  loopPkg::loopStatus_t status,
    output loopPkg::loopCfg_t    cfg
);
    import loopPkg::*;

    axiState_e        wrState;
    axiState_e        rdState;
    logic [dataW-1:0] ctrlReg;
    logic [dataW-1:0] limitReg;
    logic [dataW-1:0] offsetReg;
    logic [dataW-1:0] lockReg;
    logic             clearPulse;
    logic             awReady;
    logic             wReady;
    logic             bValid;
    logic [1:0]       bResp;
    logic             arReady;
    logic             rValid;
    logic [1:0]       rResp;
    logic [dataW-1:0] rData;
    logic             wrFire;
    logic             rdFire;
    logic             wrHit;
    logic             rdHit;
    logic [dataW-1:0] rdValue;

    function automatic logic [dataW-1:0] mergeBytes(
        input logic [dataW-1:0]   oldVal,
        input logic [dataW-1:0]   newVal,
        input logic [dataW/8-1:0] strb
    );
        logic [dataW-1:0] res;
        res = oldVal;
        for (int i = 0; i < dataW/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = newVal[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wrFire = awReady && wReady && axiReq.awvalid && axiReq.wvalid;
    assign rdFire = arReady && axiReq.arvalid;
    assign wrHit  = axiReq.awaddr inside {CTRL, LIMIT, OFFSET, LOCK};

    always_comb begin
        rdHit   = 1'b1;
        rdValue = '0;
        case (axiReq.araddr)
            CTRL:    rdValue = ctrlReg;
            LIMIT:   rdValue = limitReg;
            OFFSET:  rdValue = offsetReg;
            LOCK:    rdValue = lockReg;
            ACCUM:   rdValue = status.lagAccum;
            STATUS:  rdValue = {{(dataW-3){1'b0}}, status.satNeg, status.satPos, status.locked};
            default: rdHit = 1'b0;  // unmapped reads as zero
        endcase
    end

    // write channel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wrState    <= WR_IDLE;
            awReady    <= 1'b0;
            wReady     <= 1'b0;
            bValid     <= 1'b0;
            bResp      <= respOkay;
            clearPulse <= 1'b0;
            ctrlReg    <= '0;
            limitReg   <= '0;
            offsetReg  <= '0;
            lockReg    <= '0;
        end else begin
            clearPulse <= 1'b0;
            case (wrState)
                WR_IDLE: begin
                    if (wrFire) begin
                        awReady <= 1'b0;
                        wReady  <= 1'b0;
                        bValid  <= 1'b1;
                        bResp   <= wrHit ? respOkay : respSlvErr;
                        wrState <= WR_RESP;
                        case (axiReq.awaddr)
                            CTRL: begin
                                // clear bit is never stored, only pulsed
                                ctrlReg <= mergeBytes(ctrlReg, axiReq.wdata, axiReq.wstrb)
                                           & ~(dataW'(1) << ctrlClearBit);
                                clearPulse <= axiReq.wstrb[0] && axiReq.wdata[ctrlClearBit];
                            end
                            LIMIT:   limitReg  <= mergeBytes(limitReg, axiReq.wdata, axiReq.wstrb);
                            OFFSET:  offsetReg <= mergeBytes(offsetReg, axiReq.wdata, axiReq.wstrb);
                            LOCK:    lockReg   <= mergeBytes(lockReg, axiReq.wdata, axiReq.wstrb);
                            default: ;  // read only or unmapped
                        endcase
                    end else if (axiReq.awvalid && axiReq.wvalid) begin
                        awReady <= 1'b1;  // both halves present
                        wReady  <= 1'b1;
                    end
                end
                WR_RESP: begin
                    if (axiReq.bready) begin
                        bValid  <= 1'b0;
                        wrState <= WR_IDLE;
                    end
                end
                default: wrState <= WR_IDLE;
            endcase
        end
    end

    // read channel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdState <= RD_IDLE;
            arReady <= 1'b0;
            rValid  <= 1'b0;
            rResp   <= respOkay;
            rData   <= '0;
        end else begin
            case (rdState)
                RD_IDLE: begin
                    if (rdFire) begin
                        arReady <= 1'b0;
                        rValid  <= 1'b1;
                        rData   <= rdValue;
                        rResp   <= rdHit ? respOkay : respSlvErr;
                        rdState <= RD_DATA;
                    end else if (axiReq.arvalid) begin
                        arReady <= 1'b1;
                    end
                end
                RD_DATA: begin
                    if (axiReq.rready) begin
                        rValid  <= 1'b0;
                        rdState <= RD_IDLE;
                    end
                end
                default: rdState <= RD_IDLE;
            endcase
        end
    end

    assign axiRsp = '{awready: awReady, wready: wReady, bresp: bResp, bvalid: bValid,
                      arready: arReady, rdata: rData, rresp: rResp, rvalid: rValid};

    assign cfg = '{invertError:   ctrlReg[ctrlInvBit],
                   zeroError:     ctrlReg[ctrlZeroBit],
                   clearAccum:    clearPulse,
                   leadExp:       ctrlReg[leadLsb +: expW],
                   lagExp:        ctrlReg[lagLsb +: expW],
                   limit:         limitReg,
                   offset:        offsetReg[dataW-1 -: errW],  // top bits only
                   lockCount:     lockReg[cntW-1:0],
                   syncThreshold: lockReg[syncLsb +: errW]};

endmodule

`default_nettype wire

/* hw/loopPkg.sv */
`default_nettype none

package loopPkg;

    localparam int errW     = 12;
    localparam int dataW    = 32;
    localparam int addrW    = 12;
    localparam int expW     = 5;
    localparam int cntW     = 16;
    localparam int unityExp = 11;  // exponent for a gain of one

    // CTRL and LOCK field positions
    localparam int ctrlInvBit   = 0;
    localparam int ctrlZeroBit  = 1;
    localparam int ctrlClearBit = 2;
    localparam int leadLsb      = 8;
    localparam int lagLsb       = 16;
    localparam int syncLsb      = 16;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    typedef enum logic [addrW-1:0] {
        CTRL   = 12'h000,
        LIMIT  = 12'h004,
        OFFSET = 12'h008,
        LOCK   = 12'h00C,
        ACCUM  = 12'h010,  // read only
        STATUS = 12'h014   // read only
    } loopReg_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_RESP,
        RD_IDLE,
        RD_DATA
    } axiState_e;

    typedef struct packed {
        logic [addrW-1:0]   awaddr;
        logic               awvalid;
        logic [dataW-1:0]   wdata;
        logic [dataW/8-1:0] wstrb;
        logic               wvalid;
        logic               bready;
        logic [addrW-1:0]   araddr;
        logic               arvalid;
        logic               rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic             awready;
        logic             wready;
        logic [1:0]       bresp;
        logic             bvalid;
        logic             arready;
        logic [dataW-1:0] rdata;
        logic [1:0]       rresp;
        logic             rvalid;
    } axiLiteRsp_t;

    typedef struct packed {
        logic             invertError;
        logic             zeroError;
        logic             clearAccum;   // single cycle pulse
        logic [expW-1:0]  leadExp;
        logic [expW-1:0]  lagExp;
        logic [dataW-1:0] limit;
        logic [errW-1:0]  offset;
        logic [cntW-1:0]  lockCount;
        logic [errW-1:0]  syncThreshold;
    } loopCfg_t;

    typedef struct packed {
        logic signed [dataW-1:0] leadTerm;
        logic signed [dataW-1:0] lagTerm;
    } scaledTerms_t;

    typedef struct packed {
        logic signed [dataW-1:0] lagAccum;
        logic                    satPos;
        logic                    satNeg;
        logic                    locked;
    } loopStatus_t;

endpackage

`default_nettype wire
